/* flist.f */
+incdir+logic
logic/spidergon_pkg.sv
logic/vc_fifo.sv
logic/input_port.sv
logic/output_port.sv
logic/spidergon_node.sv
tb/tb_spidergon_node.sv

/* logic/input_port.sv */
// two-vc input buffering, per-vc route hold and per-output request generation
`include "spidergon_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module input_port
	import spidergon_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire [`SPG_NODE_W-1:0] node_id, // ring position of this node
	input wire flit_t in_flit,
	input wire in_valid,
	output logic [`SPG_NUM_VC-1:0] in_ready, // one bit per vc
	output flit_t [`SPG_NUM_VC-1:0] head_flit, // fifo head of each vc
	output logic [`SPG_NUM_PORTS-1:0][`SPG_NUM_VC-1:0] req, // [output][vc]
	input wire [`SPG_NUM_PORTS-1:0][`SPG_NUM_VC-1:0] grant // [output][vc]
);
	logic [`SPG_NUM_VC-1:0] wr_en;
	logic [`SPG_NUM_VC-1:0] rd_en;
	logic [`SPG_NUM_VC-1:0] full;
	logic [`SPG_NUM_VC-1:0] empty;

	for (genvar v = 0; v < `SPG_NUM_VC; v++)
	begin : g_vc
		logic [`SPG_NUM_PORTS-1:0] grant_col; // this vc's grant from every output
		logic is_first; // head or header waiting at fifo head
		logic is_last; // tail or header, ends the packet
		logic route_held; // a packet is in flight on this vc
		port_e route_q; // route kept for body and tail flits
		port_e route_now;
		logic vc_req;

		// ready only looks at fifo space, never at in_valid
		assign in_ready[v] = !full[v];
		assign wr_en[v] = in_valid && (in_flit.vc == `SPG_VC_W'(v)) && in_ready[v];

		vc_fifo u_fifo (
			.clk(clk),
			.reset(reset),
			.wr_en(wr_en[v]),
			.wr_flit(in_flit),
			.rd_en(rd_en[v]),
			.rd_flit(head_flit[v]),
			.full(full[v]),
			.empty(empty[v])
		);

		assign is_first = (head_flit[v].ftype == flit_head) || (head_flit[v].ftype == flit_header);
		assign is_last = (head_flit[v].ftype == flit_tail) || (head_flit[v].ftype == flit_header);

		// fresh route for a header-type flit, held route otherwise
		assign route_now = is_first ?
			spg_route(head_flit[v].data[`SPG_DATA_W-1 -: `SPG_NODE_W], node_id) : route_q;
		assign vc_req = !empty[v] && (is_first || route_held);

		for (genvar q = 0; q < `SPG_NUM_PORTS; q++)
		begin : g_out
			assign grant_col[q] = grant[q][v];
			assign req[q][v] = vc_req && (route_now == port_e'(q)); // only the routed output
		end

		assign rd_en[v] = |grant_col; // pop in the grant cycle

		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				route_held <= 1'b0;
				route_q <= port_local;
			end
			else if (rd_en[v])
			begin
				if (is_last)
					route_held <= 1'b0; // packet done, vc free for next head
				else if (is_first)
				begin
					route_held <= 1'b1;
					route_q <= route_now; // keep for the rest of the worm
				end
			end
		end

		// grants come from four separate output arbiters
		assert property (@(posedge clk) disable iff (reset) $onehot0(grant_col))
			else $error("input_port: vc %0d granted by several outputs", v);
	end

endmodule

`default_nettype wire

/* logic/output_port.sv */
// round-robin vc arbitration with wormhole lock and a registered valid/ready output
`include "spidergon_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module output_port
	import spidergon_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire [`SPG_NUM_PORTS*`SPG_NUM_VC-1:0] req_in, // index is input * vcs + vc
	input wire flit_t [`SPG_NUM_PORTS*`SPG_NUM_VC-1:0] flit_in,
	output logic [`SPG_NUM_PORTS*`SPG_NUM_VC-1:0] grant,
	output flit_t out_flit,
	output logic out_valid,
	input wire out_ready
);
	localparam int nreq = `SPG_NUM_PORTS * `SPG_NUM_VC;
	localparam int idx_w = $clog2(nreq);

	logic lock_q; // output owned by one worm
	logic [idx_w-1:0] lock_idx_q; // owner of the lock
	logic [idx_w-1:0] last_q; // last winner, rr starts after it
	logic pick_found;
	logic [idx_w-1:0] pick_idx;
	logic win_valid;
	logic [idx_w-1:0] win_idx;
	logic can_load; // register empty or draining now
	logic do_grant;
	flit_t win_flit;

	// round-robin search starting one past the last winner
	always_comb
	begin
		int cand;
		pick_found = 1'b0;
		pick_idx = '0;
		for (int i = 1; i <= nreq; i++)
		begin
			cand = (int'(last_q) + i) % nreq;
			if (!pick_found && req_in[cand])
			begin
				pick_found = 1'b1;
				pick_idx = idx_w'(cand);
			end
		end
	end

	assign can_load = !out_valid || out_ready;

	always_comb
	begin
		if (lock_q)
		begin
			win_valid = req_in[lock_idx_q]; // wait for the owner even if others ask
			win_idx = lock_idx_q;
		end
		else
		begin
			win_valid = pick_found;
			win_idx = pick_idx;
		end
		do_grant = win_valid && can_load;
		grant = '0;
		if (do_grant)
			grant[win_idx] = 1'b1;
	end

	assign win_flit = flit_in[win_idx];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			lock_q <= 1'b0;
			lock_idx_q <= '0;
			last_q <= idx_w'(nreq - 1); // first search starts at requester 0
		end
		else if (do_grant)
		begin
			out_valid <= 1'b1;
			last_q <= win_idx;
			if (win_flit.ftype == flit_head)
			begin
				lock_q <= 1'b1; // hold until the tail passes
				lock_idx_q <= win_idx;
			end
			else if (win_flit.ftype == flit_tail)
				lock_q <= 1'b0;
		end
		else if (out_ready)
			out_valid <= 1'b0; // drained, nothing new
	end

	// loads on the grant edge
	always_ff @(posedge clk)
	begin
		if (do_grant)
			out_flit <= win_flit;
	end

	// a stalled flit must be held for the receiver
	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_flit))
		else $error("output_port: out_flit changed while stalled");

endmodule

`default_nettype wire

/* logic/spidergon_cfg.svh */
// node count, flit field widths, virtual channel count and fifo depth macros
`ifndef SPIDERGON_CFG_SVH
`define SPIDERGON_CFG_SVH

`default_nettype none

// ring size and node numbering
`define SPG_NUM_NODES 8
`define SPG_NODE_W 3

// flit fields, the full flit is type + vc + data
`define SPG_DATA_W 16

// virtual channels per input
`define SPG_NUM_VC 2
`define SPG_VC_W 1

`define SPG_FIFO_DEPTH 2 // flits held by each vc fifo

`define SPG_NUM_PORTS 4 // acw, cw, across, local

`default_nettype wire

`endif

/* logic/spidergon_node.sv */
// spidergon node top with four input ports feeding four output ports
`include "spidergon_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module spidergon_node
	import spidergon_pkg::*;
#(
	parameter logic [`SPG_NODE_W-1:0] node_id = '0 // below SPG_NUM_NODES
)
(
	input wire clk,
	input wire reset,
	input wire flit_t [`SPG_NUM_PORTS-1:0] in_flit, // all port vectors indexed by port_e
	input wire [`SPG_NUM_PORTS-1:0] in_valid,
	output logic [`SPG_NUM_PORTS-1:0][`SPG_NUM_VC-1:0] in_ready,
	output flit_t [`SPG_NUM_PORTS-1:0] out_flit,
	output logic [`SPG_NUM_PORTS-1:0] out_valid,
	input wire [`SPG_NUM_PORTS-1:0] out_ready
);
	localparam int np = `SPG_NUM_PORTS;
	localparam int nv = `SPG_NUM_VC;
	localparam int nr = np * nv; // requesters per output

	// input side view, [input][output][vc]
	logic [np-1:0][np-1:0][nv-1:0] req_i;
	logic [np-1:0][np-1:0][nv-1:0] grant_i;
	flit_t [np-1:0][nv-1:0] head_i;

	// output side view, [output][input * nv + vc]
	logic [np-1:0][nr-1:0] req_o;
	logic [np-1:0][nr-1:0] grant_o;
	flit_t [np-1:0][nr-1:0] flit_o;

	for (genvar p = 0; p < np; p++)
	begin : g_in
		input_port u_in (
			.clk(clk),
			.reset(reset),
			.node_id(node_id),
			.in_flit(in_flit[p]),
			.in_valid(in_valid[p]),
			.in_ready(in_ready[p]),
			.head_flit(head_i[p]),
			.req(req_i[p]),
			.grant(grant_i[p])
		);
	end

	for (genvar q = 0; q < np; q++)
	begin : g_out
		for (genvar p = 0; p < np; p++)
		begin : g_src
			for (genvar v = 0; v < nv; v++)
			begin : g_vc
				assign req_o[q][p*nv+v] = req_i[p][q][v];
				assign flit_o[q][p*nv+v] = head_i[p][v]; // every output sees every vc head
				assign grant_i[p][q][v] = grant_o[q][p*nv+v];
			end
		end

		output_port u_out (
			.clk(clk),
			.reset(reset),
			.req_in(req_o[q]),
			.flit_in(flit_o[q]),
			.grant(grant_o[q]),
			.out_flit(out_flit[q]),
			.out_valid(out_valid[q]),
			.out_ready(out_ready[q])
		);
	end

endmodule

`default_nettype wire

/* logic/spidergon_pkg.sv */
// flit type and port enums, flit struct and the spidergon route function
`include "spidergon_cfg.svh"
`default_nettype none

package spidergon_pkg;

	typedef enum logic [1:0] {
		flit_tail   = 2'b00,
		flit_head   = 2'b01,
		flit_body   = 2'b10,
		flit_header = 2'b11 // single flit packet, head and tail at once
	} flit_type_e;

	// same order as the port vectors of the node
	typedef enum logic [1:0] {
		port_acw    = 2'd0, // anticlockwise neighbour
		port_cw     = 2'd1, // clockwise neighbour
		port_across = 2'd2, // node opposite on the ring
		port_local  = 2'd3  // ejection to the processor
	} port_e;

	typedef struct packed {
		flit_type_e ftype;
		logic [`SPG_VC_W-1:0] vc; // vc chosen by the sender
		logic [`SPG_DATA_W-1:0] data; // head and header: dest, src, payload
	} flit_t;

	// shortest-path rule: near quarter goes around, the rest goes across
	function automatic port_e spg_route(
		input logic [`SPG_NODE_W-1:0] dest,
		input logic [`SPG_NODE_W-1:0] cur
	);
		int rel;
		port_e dir;
		rel = (int'(dest) - int'(cur) + `SPG_NUM_NODES) % `SPG_NUM_NODES; // hops clockwise
		if (rel == 0)
			dir = port_local;
		else if (4 * rel <= `SPG_NUM_NODES)
			dir = port_cw;
		else if (4 * rel >= 3 * `SPG_NUM_NODES)
			dir = port_acw;
		else
			dir = port_across;
		return dir;
	endfunction

endpackage

`default_nettype wire

/* logic/vc_fifo.sv */
// virtual channel flit fifo with full and empty flags
`include "spidergon_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module vc_fifo
	import spidergon_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire wr_en,
	input wire flit_t wr_flit,
	input wire rd_en,
	output flit_t rd_flit, // current fifo head
	output logic full,
	output logic empty
);
	localparam int depth = `SPG_FIFO_DEPTH;
	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	flit_t mem [depth]; // flit storage
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count; // flits currently stored

	// circular increment, depth need not be a power of two
	function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = (count == cnt_w'(depth));
	assign empty = (count == '0);
	assign rd_flit = mem[rd_ptr]; // new write shows up here one cycle later

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= ptr_next(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_next(rd_ptr);
			if (wr_en && !rd_en)
				count <= count + 1'b1; // push only
			else if (rd_en && !wr_en)
				count <= count - 1'b1; // pop only
		end
	end

	// writer is the input port, reader is the output arbiter
	assert property (@(posedge clk) disable iff (reset) wr_en |-> !full)
		else $error("vc_fifo: write while full");
	assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty)
		else $error("vc_fifo: read while empty");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the spidergon node testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_spidergon_node -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_spidergon_node > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
	exit 0
fi
exit 1

/* tb/tb_spidergon_node.sv */
// testbench for the spidergon node with lfsr packets, route reference, scoreboard and watchdog
`include "spidergon_cfg.svh"
`timescale 1ns/100ps
`default_nettype none

module tb_spidergon_node
	import spidergon_pkg::*;
();
	localparam int np = `SPG_NUM_PORTS;
	localparam int nv = `SPG_NUM_VC;
	localparam int ns = np * nv; // sources, input * nv + vc
	localparam int this_node = 3;

	logic clk;
	logic reset;
	flit_t [np-1:0] in_flit;
	logic [np-1:0] in_valid;
	logic [np-1:0][nv-1:0] in_ready;
	flit_t [np-1:0] out_flit;
	logic [np-1:0] out_valid;
	logic [np-1:0] out_ready;

	logic [31:0] lfsr;
	flit_t drv_q[ns][$]; // flits still to be driven, per source
	flit_t exp_q[np*ns][$]; // expected flits, per output and source
	int pend_out[np]; // flits still due at each output
	int outstanding;
	int n_flits;
	int n_recv;
	int n_val_err;
	int n_other_err;
	int cycles;
	int pick[np]; // next vc tried first on each input
	logic [np-1:0] hold; // output held at out_ready low
	logic rand_ready;
	logic [np-1:0] open_pkt; // a worm is passing this output
	int open_src[np];
	logic [np-1:0] stalled;
	flit_t [np-1:0] stall_flit;

	spidergon_node #(.node_id(3'd3)) dut0 (
		.clk(clk),
		.reset(reset),
		.in_flit(in_flit),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_flit(out_flit),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int take_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr); // one step per bit
			r = (r << 1) | int'(lfsr[0]);
		end
		return r;
	endfunction

	// header only or 3 to 5 flits
	function automatic int rand_len();
		int k;
		k = take_bits(2);
		return (k == 0) ? 1 : k + 2;
	endfunction

	// expected output for a destination seen from node 3
	function automatic int expected_port(input int dest);
		int rel;
		rel = (dest - this_node + `SPG_NUM_NODES) % `SPG_NUM_NODES; // hops going clockwise
		if (rel == 0)
			return int'(port_local);
		if (rel <= `SPG_NUM_NODES / 4)
			return int'(port_cw);
		if (rel >= 3 * `SPG_NUM_NODES / 4)
			return int'(port_acw);
		return int'(port_across);
	endfunction

	// source tag sits in the payload of heads, at the top of body and tail data
	function automatic int source_of(input flit_t f);
		if (f.ftype == flit_head || f.ftype == flit_header)
			return int'(f.data[9:7]);
		return int'(f.data[15:13]);
	endfunction

	task automatic queue_packet(input int p, input int v, input int dest, input int len);
		flit_t f;
		int q;
		int src;
		q = expected_port(dest);
		src = p * nv + v;
		for (int i = 0; i < len; i++)
		begin
			f.vc = `SPG_VC_W'(v);
			if (i == 0)
			begin
				f.ftype = (len == 1) ? flit_header : flit_head;
				f.data = {3'(dest), 3'(this_node), 3'(src), 7'(take_bits(7))}; // dest, src, payload
			end
			else
			begin
				f.ftype = (i == len - 1) ? flit_tail : flit_body;
				f.data = {3'(src), 5'(i), 8'(take_bits(8))}; // tag, sequence, filler
			end
			drv_q[src].push_back(f);
			exp_q[q * ns + src].push_back(f);
			pend_out[q]++;
			outstanding++;
			n_flits++;
		end
	endtask

	task automatic wait_drain();
		while (outstanding != 0)
			@(posedge clk);
		@(posedge clk);
	endtask

	task automatic check_idle();
		if (out_valid != '0)
		begin
			$display("ERR out_valid exp 0 got %h", out_valid);
			n_val_err++;
		end
		if (in_ready != '1)
		begin
			$display("ERR in_ready exp ff got %h", in_ready);
			n_val_err++;
		end
	endtask

	// drives inputs and out_ready just after each edge
	always @(posedge clk)
	begin
		int v;
		#2;
		for (int q = 0; q < np; q++)
			out_ready[q] = rand_ready ? (take_bits(1) != 0) : !hold[q];
		for (int p = 0; p < np; p++)
		begin
			in_valid[p] = 1'b0;
			for (int k = 0; k < nv; k++)
			begin
				v = (pick[p] + k) % nv; // alternate vcs, skip a full one
				if (!reset && !in_valid[p] && drv_q[p*nv+v].size() > 0 && in_ready[p][v])
				begin
					in_flit[p] = drv_q[p*nv+v].pop_front(); // ready is stable until the edge
					in_valid[p] = 1'b1;
					pick[p] = (v + 1) % nv;
				end
			end
		end
	end

	// compare at the falling edge, away from every update
	always @(negedge clk)
	begin
		int src;
		int key;
		flit_t want;
		if (!reset)
		begin
			for (int q = 0; q < np; q++)
			begin
				if (stalled[q] && !out_valid[q])
				begin
					$display("ERR out_valid[%0d] under stall exp 1 got 0", q);
					n_val_err++;
				end
				if (stalled[q] && out_flit[q] != stall_flit[q])
				begin
					$display("ERR out_flit[%0d] under stall exp %h got %h", q, stall_flit[q],
						out_flit[q]);
					n_val_err++;
				end
				stalled[q] = out_valid[q] && !out_ready[q];
				stall_flit[q] = out_flit[q];
				if (out_valid[q] && out_ready[q])
				begin
					src = source_of(out_flit[q]);
					key = q * ns + src;
					if (open_pkt[q] && src != open_src[q])
					begin
						$display("ERR out_flit[%0d] source exp %h got %h", q, open_src[q], src);
						n_val_err++;
					end
					if (exp_q[key].size() == 0)
					begin
						$display("output %0d delivered a flit nobody sent there: %h", q, out_flit[q]);
						n_other_err++;
					end
					else
					begin
						want = exp_q[key].pop_front();
						if (out_flit[q] != want)
						begin
							$display("ERR out_flit[%0d] exp %h got %h", q, want, out_flit[q]);
							n_val_err++;
						end
						pend_out[q]--;
						outstanding--;
						n_recv++;
					end
					if (out_flit[q].ftype == flit_head)
					begin
						open_pkt[q] = 1'b1;
						open_src[q] = src;
					end
					else if (out_flit[q].ftype != flit_body)
						open_pkt[q] = 1'b0; // tail or header closes the worm
				end
			end
		end
	end

	// limit grows with every flit queued
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > 30 * n_flits + 200)
		begin
			$display("timeout after %0d cycles with %0d flits never delivered", cycles,
				outstanding);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		int p;
		int v;
		int d;
		int waited;
		lfsr = 32'hd9f7af17;
		reset = 1'b1;
		in_flit = '0;
		in_valid = '0;
		out_ready = '1;
		hold = '0;
		rand_ready = 1'b0;
		open_pkt = '0;
		stalled = '0;
		stall_flit = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// idle state straight after reset
		@(negedge clk);
		check_idle();

		// one header from every input to every destination
		@(posedge clk);
		for (p = 0; p < np; p++)
			for (d = 0; d < `SPG_NUM_NODES; d++)
				if (!(p == int'(port_local) && d == this_node))
					queue_packet(p, d % nv, d, 1);
		wait_drain();

		// two inputs compete for the across output, node 7
		for (int i = 0; i < 3; i++)
		begin
			queue_packet(int'(port_acw), 0, 7, 3 + take_bits(2) % 3);
			queue_packet(int'(port_cw), 1, 7, 3 + take_bits(2) % 3);
		end
		wait_drain();

		// vc 0 stuck on a held cw output, vc 1 must pass to acw
		hold[port_cw] = 1'b1;
		@(posedge clk);
		queue_packet(int'(port_across), 0, 4, 5); // one hop clockwise
		queue_packet(int'(port_across), 1, 1, 5); // two hops anticlockwise
		waited = 0;
		while (pend_out[port_acw] != 0 && waited < 100)
		begin
			@(posedge clk);
			waited++;
		end
		if (pend_out[port_acw] != 0)
		begin
			$display("vc 1 packet did not get past the stalled clockwise output");
			n_other_err++;
		end
		hold = '0;
		wait_drain();

		// random traffic under random back-pressure
		for (int i = 0; i < 30; i++)
		begin
			p = take_bits(2);
			v = take_bits(1);
			d = take_bits(3);
			if (p == int'(port_local) && d == this_node)
				d = 0; // processor never sends to itself
			queue_packet(p, v, d, rand_len());
		end
		rand_ready = 1'b1; // lfsr belongs to the driver from here
		wait_drain();
		rand_ready = 1'b0;

		$display("done: %0d flits sent, %0d received, %0d value errors, %0d other errors",
			n_flits, n_recv, n_val_err, n_other_err);
		if (n_val_err + n_other_err == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
